/* rtl/mf2_pkg.sv */
// Multiface Two package with shared types, vectors, windows and shadow RAM locations
package mf2_pkg;

	// Index into the 8 KB add-on RAM
	typedef logic [12:0] mf2_addr_t;
	typedef logic [7:0] byte_t;

	// Front-panel mode selector
	typedef enum logic [1:0] {
		MODE_ENABLED  = 2'd0,
		MODE_HIDDEN   = 2'd1,
		MODE_DISABLED = 2'd2
	} mf2_mode_e;

	////////////////////////////////////////
	// Fetch vectors and ports
	////////////////////////////////////////

	localparam logic [15:0] NMI_VECTOR  = 16'h0066;
	localparam logic [15:0] HIDE_VECTOR = 16'h0065;

	// FEE8 / FEEA, bit 1 picks page-out
	localparam logic [13:0] CTRL_PORT_PREFIX = 14'b11111110111010;

	// CPU address bits 15..13
	localparam logic [2:0] ROM_WINDOW = 3'b000;
	localparam logic [2:0] RAM_WINDOW = 3'b001;

	////////////////////////////////////////
	// Shadow register locations
	////////////////////////////////////////

	localparam mf2_addr_t SHADOW_PEN_INDEX   = 13'h1FCF;
	localparam mf2_addr_t SHADOW_PEN_BASE    = 13'h1F90;
	localparam mf2_addr_t SHADOW_BORDER      = 13'h1FDF;
	localparam mf2_addr_t SHADOW_MODE        = 13'h1FEF;
	localparam mf2_addr_t SHADOW_BANKING     = 13'h1FFF;
	localparam mf2_addr_t SHADOW_CRTC_SELECT = 13'h1CFF;
	localparam mf2_addr_t SHADOW_CRTC_BASE   = 13'h1DB0;
	localparam mf2_addr_t SHADOW_PPI         = 13'h17FF;
	localparam mf2_addr_t SHADOW_UPPER_ROM   = 13'h1AAC;

	// Floating bus value, ANDed with other sources upstream
	localparam byte_t IDLE_DATA = 8'hFF;

endpackage

/* rtl/mf2_store_decode.sv */
// Port-write decoder mapping hardware register writes to shadow RAM locations
`timescale 1ns/1ps

module mf2_store_decode (
	input  logic [15:0]       cpu_addr,
	input  mf2_pkg::byte_t    cpu_dout,
	input  logic [4:0]        pen_index,
	input  logic [3:0]        crtc_register,
	output mf2_pkg::mf2_addr_t store_addr,
	output logic              store_hit,
	output logic              pen_capture,
	output logic              crtc_capture
);

	import mf2_pkg::*;

	// High byte of the port selects the target register
	always_comb begin
		store_addr   = '0;
		pen_capture  = 1'b0;
		crtc_capture = 1'b0;

		case (cpu_addr[15:8])
			8'h7F: begin
				// Gate array, function in data bits 7..6
				case (cpu_dout[7:6])
					2'b00: begin
						store_addr  = SHADOW_PEN_INDEX;
						pen_capture = 1'b1;
					end
					2'b01: begin
						// Index bit 4 selects the border
						if (pen_index[4]) begin
							store_addr = SHADOW_BORDER;
						end else begin
							store_addr = {SHADOW_PEN_BASE[12:4], pen_index[3:0]};
						end
					end
					2'b10: store_addr = SHADOW_MODE;
					default: store_addr = SHADOW_BANKING;
				endcase
			end
			8'hBC: begin
				store_addr   = SHADOW_CRTC_SELECT;
				crtc_capture = 1'b1;
			end
			8'hBD: store_addr = {SHADOW_CRTC_BASE[12:4], crtc_register};
			8'hF7: store_addr = SHADOW_PPI;
			8'hDF: store_addr = SHADOW_UPPER_ROM;
			default: store_addr = '0;
		endcase
	end

	// No shadow slot lives at address zero
	assign store_hit = |store_addr;

endmodule

/* rtl/mf2_control.sv */
// Multiface Two control with NMI request, paging, hiding and RAM command sequencing
`timescale 1ns/1ps

module mf2_control (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic [15:0]        cpu_addr,
	input  mf2_pkg::byte_t     cpu_dout,
	input  logic               m1,
	input  logic               io_wr,
	input  logic               mem_wr,
	input  logic               key_nmi,
	input  mf2_pkg::mf2_mode_e mode,
	input  mf2_pkg::mf2_addr_t store_addr,
	input  logic               store_hit,
	input  logic               pen_capture,
	input  logic               crtc_capture,
	output logic [4:0]         pen_index,
	output logic [3:0]         crtc_register,
	output mf2_pkg::mf2_addr_t ram_addr,
	output mf2_pkg::byte_t     ram_wdata,
	output logic               ram_we,
	output logic               nmi,
	output logic               mf2_en,
	output logic               ram_sel,
	output logic               rom_sel
);

	import mf2_pkg::*;

	logic m1_q, m1_qq;
	logic io_wr_q, io_wr_qq;
	logic key_q, key_qq;
	logic mem_wr_q;
	logic hidden;

	logic m1_rise;
	logic io_wr_rise;
	logic key_rise;
	logic ctrl_port;

	////////////////////////////////////////
	// Bus strobe sampling
	////////////////////////////////////////

	// Two stages, edge is seen one cycle after the level
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			m1_q     <= 1'b0;
			m1_qq    <= 1'b0;
			io_wr_q  <= 1'b0;
			io_wr_qq <= 1'b0;
			key_q    <= 1'b0;
			key_qq   <= 1'b0;
			mem_wr_q <= 1'b0;
		end else begin
			m1_q     <= m1;
			m1_qq    <= m1_q;
			io_wr_q  <= io_wr;
			io_wr_qq <= io_wr_q;
			key_q    <= key_nmi;
			key_qq   <= key_q;
			mem_wr_q <= mem_wr;
		end
	end

	assign m1_rise    = m1_q & ~m1_qq;
	assign io_wr_rise = io_wr_q & ~io_wr_qq;
	assign key_rise   = key_q & ~key_qq;
	assign ctrl_port  = cpu_addr[15:2] == CTRL_PORT_PREFIX;

	// Windows only while paged in
	assign rom_sel = mf2_en & (cpu_addr[15:13] == ROM_WINDOW);
	assign ram_sel = mf2_en & (cpu_addr[15:13] == RAM_WINDOW);

	////////////////////////////////////////
	// NMI, paging and hiding
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nmi    <= 1'b0;
			mf2_en <= 1'b0;
			hidden <= mode != MODE_ENABLED;
		end else begin
			if (key_rise && !mf2_en && mode != MODE_DISABLED) begin
				nmi <= 1'b1;
			end

			// Vector fetch pages the add-on in and unhides it
			if (m1_rise && nmi && cpu_addr == NMI_VECTOR) begin
				nmi    <= 1'b0;
				mf2_en <= 1'b1;
				hidden <= 1'b0;
			end

			if (m1_rise && mf2_en && cpu_addr == HIDE_VECTOR) begin
				hidden <= 1'b1;
			end

			// FEEA out, FEE8 in unless hidden
			if (io_wr_rise && ctrl_port) begin
				mf2_en <= ~cpu_addr[1] & ~hidden;
			end
		end
	end

	////////////////////////////////////////
	// RAM command
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_we <= 1'b0;
		end else if (io_wr_rise && ctrl_port) begin
			ram_we <= 1'b0;
		end else if (io_wr_rise && store_hit) begin
			ram_we <= 1'b1;
		end else if (mem_wr_q && ram_sel) begin
			ram_we <= 1'b1;
		end else begin
			ram_we <= 1'b0;
		end
	end

	// Address, data and register context, same priority as above
	always_ff @(posedge clk_sys) begin
		if (io_wr_rise && ctrl_port) begin
			ram_addr <= ram_addr;
		end else if (io_wr_rise && store_hit) begin
			ram_addr  <= store_addr;
			ram_wdata <= cpu_dout;
			if (pen_capture) begin
				pen_index <= cpu_dout[4:0];
			end
			if (crtc_capture) begin
				crtc_register <= cpu_dout[3:0];
			end
		end else if (mem_wr_q && ram_sel) begin
			ram_addr  <= cpu_addr[12:0];
			ram_wdata <= cpu_dout;
		end else begin
			// plain read of the window
			ram_addr <= cpu_addr[12:0];
		end
	end

	a_windows_exclusive: assert property (
		@(posedge clk_sys) disable iff (reset) !(ram_sel && rom_sel)
	);

endmodule

/* rtl/mf2_ram.sv */
// Multiface Two 8 KB RAM with write-through read register and gated read data
`timescale 1ns/1ps

module mf2_ram (
	input  logic               clk_sys,
	input  mf2_pkg::mf2_addr_t ram_addr,
	input  mf2_pkg::byte_t     ram_wdata,
	input  logic               ram_we,
	input  logic               ram_sel,
	input  logic               mem_rd,
	output mf2_pkg::byte_t     dout
);

	import mf2_pkg::*;

	localparam int RAM_DEPTH = 1 << $bits(mf2_addr_t);

	byte_t mem [0:RAM_DEPTH-1];
	byte_t rd_data;

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	// Written byte shows up on the read port at once
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_addr] <= ram_wdata;
			rd_data       <= ram_wdata;
		end else begin
			rd_data <= mem[ram_addr];
		end
	end

	////////////////////////////////////////
	// Read data bus
	////////////////////////////////////////

	// Idle value lets other sources share the bus
	assign dout = (ram_sel && mem_rd) ? rd_data : IDLE_DATA;

	a_write_addr_known: assert property (
		@(posedge clk_sys) ram_we |-> !$isunknown(ram_addr)
	);

endmodule

/* rtl/mf2_top.sv */
// Multiface Two top level joining port decode, control and RAM on the CPU bus
`timescale 1ns/1ps

module mf2_top (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic [15:0]        cpu_addr,
	input  mf2_pkg::byte_t     cpu_dout,
	input  logic               m1,
	input  logic               io_wr,
	input  logic               mem_rd,
	input  logic               mem_wr,
	input  logic               key_nmi,
	input  mf2_pkg::mf2_mode_e mode,
	output logic               nmi,
	output logic               mf2_en,
	output logic               ram_sel,
	output logic               rom_sel,
	output mf2_pkg::byte_t     dout
);

	import mf2_pkg::*;

	// Decode to control
	mf2_addr_t store_addr;
	logic      store_hit;
	logic      pen_capture;
	logic      crtc_capture;

	// Register context back to decode
	logic [4:0] pen_index;
	logic [3:0] crtc_register;

	// RAM command
	mf2_addr_t ram_addr;
	byte_t     ram_wdata;
	logic      ram_we;

	////////////////////////////////////////
	// Port-write decode
	////////////////////////////////////////

	mf2_store_decode i_mf2_store_decode (
		.cpu_addr      (cpu_addr),
		.cpu_dout      (cpu_dout),
		.pen_index     (pen_index),
		.crtc_register (crtc_register),
		.store_addr    (store_addr),
		.store_hit     (store_hit),
		.pen_capture   (pen_capture),
		.crtc_capture  (crtc_capture)
	);

	////////////////////////////////////////
	// Paging and NMI control
	////////////////////////////////////////

	mf2_control i_mf2_control (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cpu_addr      (cpu_addr),
		.cpu_dout      (cpu_dout),
		.m1            (m1),
		.io_wr         (io_wr),
		.mem_wr        (mem_wr),
		.key_nmi       (key_nmi),
		.mode          (mode),
		.store_addr    (store_addr),
		.store_hit     (store_hit),
		.pen_capture   (pen_capture),
		.crtc_capture  (crtc_capture),
		.pen_index     (pen_index),
		.crtc_register (crtc_register),
		.ram_addr      (ram_addr),
		.ram_wdata     (ram_wdata),
		.ram_we        (ram_we),
		.nmi           (nmi),
		.mf2_en        (mf2_en),
		.ram_sel       (ram_sel),
		.rom_sel       (rom_sel)
	);

	////////////////////////////////////////
	// Add-on RAM
	////////////////////////////////////////

	mf2_ram i_mf2_ram (
		.clk_sys   (clk_sys),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_we    (ram_we),
		.ram_sel   (ram_sel),
		.mem_rd    (mem_rd),
		.dout      (dout)
	);

endmodule

/* bench/mf2_tb_table.svh */
// Multiface Two stimulus table with expected nmi, paging, window selects and read data
`ifndef MF2_TB_TABLE_SVH
`define MF2_TB_TABLE_SVH

// Operation, address, data and mode, then expected nmi, mf2_en, ram_sel, rom_sel and dout
task automatic fill_table();
	// After reset
	add_row(OP_IDLE,      16'h0000, 8'h00, MODE_ENABLED,  1'b0, 1'b0, 1'b0, 1'b0, 8'hFF);

	// NMI request and paging in
	add_row(OP_KEY,       16'h0000, 8'h00, MODE_ENABLED,  1'b1, 1'b0, 1'b0, 1'b0, 8'hFF);
	add_row(OP_FETCH,     16'h0066, 8'h00, MODE_ENABLED,  1'b0, 1'b1, 1'b0, 1'b1, 8'hFF);
	add_row(OP_IDLE,      16'h1FFF, 8'h00, MODE_ENABLED,  1'b0, 1'b1, 1'b0, 1'b1, 8'hFF);
	add_row(OP_IDLE,      16'h2000, 8'h00, MODE_ENABLED,  1'b0, 1'b1, 1'b1, 1'b0, 8'hFF);

	// Window RAM
	add_row(OP_MEM_WRITE, 16'h2345, 8'hA5, MODE_ENABLED,  1'b0, 1'b1, 1'b1, 1'b0, 8'hFF);
	add_row(OP_MEM_READ,  16'h2345, 8'h00, MODE_ENABLED,  1'b0, 1'b1, 1'b1, 1'b0, 8'hA5);
	add_row(OP_MEM_READ,  16'h4000, 8'h00, MODE_ENABLED,  1'b0, 1'b1, 1'b0, 1'b0, 8'hFF);

	// Shadow stores of pen 3 and its colour, then CRTC register 7 and its value
	add_row(OP_IO_WRITE,  16'h7F00, 8'h03, MODE_ENABLED,  1'b0, 1'b1, 1'b0, 1'b0, 8'hFF);
	add_row(OP_IO_WRITE,  16'h7F00, 8'h4C, MODE_ENABLED,  1'b0, 1'b1, 1'b0, 1'b0, 8'hFF);
	add_row(OP_IO_WRITE,  16'hBC00, 8'h07, MODE_ENABLED,  1'b0, 1'b1, 1'b0, 1'b0, 8'hFF);
	add_row(OP_IO_WRITE,  16'hBD00, 8'h1E, MODE_ENABLED,  1'b0, 1'b1, 1'b0, 1'b0, 8'hFF);
	add_row(OP_MEM_READ,  16'h3FCF, 8'h00, MODE_ENABLED,  1'b0, 1'b1, 1'b1, 1'b0, 8'h03);
	add_row(OP_MEM_READ,  16'h3F93, 8'h00, MODE_ENABLED,  1'b0, 1'b1, 1'b1, 1'b0, 8'h4C);
	add_row(OP_MEM_READ,  16'h3CFF, 8'h00, MODE_ENABLED,  1'b0, 1'b1, 1'b1, 1'b0, 8'h07);
	add_row(OP_MEM_READ,  16'h3DB7, 8'h00, MODE_ENABLED,  1'b0, 1'b1, 1'b1, 1'b0, 8'h1E);

	// Control ports page out and in until a hide fetch blocks FEE8
	add_row(OP_IO_WRITE,  16'hFEEA, 8'h00, MODE_ENABLED,  1'b0, 1'b0, 1'b0, 1'b0, 8'hFF);
	add_row(OP_IO_WRITE,  16'hFEE8, 8'h00, MODE_ENABLED,  1'b0, 1'b1, 1'b0, 1'b0, 8'hFF);
	add_row(OP_FETCH,     16'h0065, 8'h00, MODE_ENABLED,  1'b0, 1'b1, 1'b0, 1'b1, 8'hFF);
	add_row(OP_IO_WRITE,  16'hFEEA, 8'h00, MODE_ENABLED,  1'b0, 1'b0, 1'b0, 1'b0, 8'hFF);
	add_row(OP_IO_WRITE,  16'hFEE8, 8'h00, MODE_ENABLED,  1'b0, 1'b0, 1'b0, 1'b0, 8'hFF);

	// Disabled mode ignores the key and starts hidden
	add_row(OP_RESET,     16'h0000, 8'h00, MODE_DISABLED, 1'b0, 1'b0, 1'b0, 1'b0, 8'hFF);
	add_row(OP_KEY,       16'h0000, 8'h00, MODE_DISABLED, 1'b0, 1'b0, 1'b0, 1'b0, 8'hFF);
	add_row(OP_IO_WRITE,  16'hFEE8, 8'h00, MODE_DISABLED, 1'b0, 1'b0, 1'b0, 1'b0, 8'hFF);
endtask

`endif

/* bench/mf2_tb.sv */
// Multiface Two testbench running a table of bus operations against the top level
`timescale 1ns/1ps

module mf2_tb;

	import mf2_pkg::*;

	typedef enum logic [2:0] {
		OP_IDLE,
		OP_FETCH,
		OP_IO_WRITE,
		OP_MEM_WRITE,
		OP_MEM_READ,
		OP_KEY,
		OP_RESET
	} op_e;

	logic        clk_sys;
	logic        reset;
	logic [15:0] cpu_addr;
	byte_t       cpu_dout;
	logic        m1;
	logic        io_wr;
	logic        mem_rd;
	logic        mem_wr;
	logic        key_nmi;
	mf2_mode_e   mode;
	logic        nmi;
	logic        mf2_en;
	logic        ram_sel;
	logic        rom_sel;
	byte_t       dout;

	// Table columns with one entry per row
	op_e         row_op[$];
	logic [15:0] row_addr[$];
	byte_t       row_data[$];
	mf2_mode_e   row_mode[$];
	logic        row_nmi[$];
	logic        row_en[$];
	logic        row_ram[$];
	logic        row_rom[$];
	byte_t       row_dout[$];

	logic table_ready;
	int   current_row;

	mf2_top i_mf2_top (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu_addr (cpu_addr),
		.cpu_dout (cpu_dout),
		.m1       (m1),
		.io_wr    (io_wr),
		.mem_rd   (mem_rd),
		.mem_wr   (mem_wr),
		.key_nmi  (key_nmi),
		.mode     (mode),
		.nmi      (nmi),
		.mf2_en   (mf2_en),
		.ram_sel  (ram_sel),
		.rom_sel  (rom_sel),
		.dout     (dout)
	);

	task automatic add_row(input op_e op, input logic [15:0] addr, input byte_t data,
		input mf2_mode_e md, input logic exp_nmi, input logic exp_en, input logic exp_ram,
		input logic exp_rom, input byte_t exp_dout);
		row_op.push_back(op);
		row_addr.push_back(addr);
		row_data.push_back(data);
		row_mode.push_back(md);
		row_nmi.push_back(exp_nmi);
		row_en.push_back(exp_en);
		row_ram.push_back(exp_ram);
		row_rom.push_back(exp_rom);
		row_dout.push_back(exp_dout);
	endtask

	`include "mf2_tb_table.svh"

	////////////////////////////////////////
	// Clock and watchdog
	////////////////////////////////////////

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// Budget of five cycles per row plus reset margin
	initial begin
		int limit;
		wait (table_ready);
		limit = row_op.size() * 5 + 20;
		repeat (limit) @(posedge clk_sys);
		$display("Timeout: the table did not finish within %0d clock cycles", limit);
		$display("TESTS FAILED");
		$fatal(1, "Run stopped by the watchdog");
	end

	////////////////////////////////////////
	// Driving and checking
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED row %0d: %s got %h expected %h",
				current_row, name, actual, expected);
			$display("TESTS FAILED");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	task automatic drop_strobes();
		m1      = 1'b0;
		io_wr   = 1'b0;
		mem_rd  = 1'b0;
		mem_wr  = 1'b0;
		key_nmi = 1'b0;
	endtask

	// Reset held for four clocks and released on a falling edge
	task automatic do_reset(input mf2_mode_e md);
		@(negedge clk_sys);
		drop_strobes();
		mode  = md;
		reset = 1'b1;
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	task automatic apply_row(input int idx);
		if (row_op[idx] == OP_RESET) begin
			do_reset(row_mode[idx]);
		end else begin
			@(negedge clk_sys);
		end
		cpu_addr = row_addr[idx];
		cpu_dout = row_data[idx];
		mode     = row_mode[idx];
		case (row_op[idx])
			OP_FETCH:     m1 = 1'b1;
			OP_IO_WRITE:  io_wr = 1'b1;
			OP_MEM_WRITE: mem_wr = 1'b1;
			OP_MEM_READ:  mem_rd = 1'b1;
			OP_KEY:       key_nmi = 1'b1;
			default:      ;
		endcase
		// Three clocks cover edge detect, state update and RAM read
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic check_row(input int idx);
		check_value("nmi", nmi, row_nmi[idx]);
		check_value("mf2_en", mf2_en, row_en[idx]);
		check_value("ram_sel", ram_sel, row_ram[idx]);
		check_value("rom_sel", rom_sel, row_rom[idx]);
		check_value("dout", dout, row_dout[idx]);
	endtask

	initial begin
		table_ready = 1'b0;
		current_row = 0;
		reset       = 1'b1;
		cpu_addr    = 16'h0000;
		cpu_dout    = 8'h00;
		mode        = MODE_ENABLED;
		drop_strobes();

		fill_table();
		table_ready = 1'b1;

		do_reset(MODE_ENABLED);

		for (int i = 0; i < row_op.size(); i++) begin
			current_row = i;
			apply_row(i);
			check_row(i);
			// Strobes low for a clock so the next row makes a fresh edge
			drop_strobes();
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* flist.f */
+incdir+bench
rtl/mf2_pkg.sv
rtl/mf2_store_decode.sv
rtl/mf2_control.sv
rtl/mf2_ram.sv
rtl/mf2_top.sv
bench/mf2_tb.sv
